// ==== Makefile ====
# Verilator build and run of the pipeline back-end testbench

TOP = tb_back_end
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -x '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
hw/pipeline_pkg.sv
hw/data_mem.sv
hw/virtual_wb.sv
hw/stage_ma.sv
hw/stage_wb.sv
hw/reg_file.sv
hw/operand_fwd.sv
hw/back_end_top.sv
sim/back_end_sva.sv
sim/back_end_checker.sv
sim/tb_back_end.sv

// ==== hw/back_end_top.sv ====
//////////////////////////////////////////////////////////////////////
// Pipeline back end
// Memory access, write-back, register file and operand forwarding
// of a five-stage 32-bit load/store pipeline
//////////////////////////////////////////////////////////////////////

module back_end_top #(
  parameter int DMEM_WORDS = 256  // Data RAM depth, power of two
) (
  input  logic                                clk,
  input  logic                                i_rst,
  // Execute-stage results
  input  logic [pipeline_pkg::XLEN-1:0]       i_ma_pc,
  input  logic [pipeline_pkg::XLEN-1:0]       i_ma_alu_rslt,
  input  logic [pipeline_pkg::XLEN-1:0]       i_ma_store_data,
  input  pipeline_pkg::mem_op_e               i_ma_mem_op,
  input  pipeline_pkg::wb_sel_e               i_ma_wb_sel,
  input  logic                                i_ma_reg_write,
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_ma_rdst,
  // Next instruction's sources
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_rs_a,
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_rs_b,
  // Write-back view
  output logic [pipeline_pkg::XLEN-1:0]       o_wb_mux,
  output logic [pipeline_pkg::REG_ADDR_W-1:0] o_wb_rdst,
  output logic                                o_wb_reg_write_rf,
  output pipeline_pkg::wb_sel_e               o_wb_reg_dst_s,
  output logic [pipeline_pkg::REG_ADDR_W-1:0] o_vwb_rdst,
  output logic                                o_vwb_reg_write_rf,
  output logic [pipeline_pkg::XLEN-1:0]       o_vwb_mux,
  // Resolved operands, one cycle after i_rs_*
  output logic [pipeline_pkg::XLEN-1:0]       o_opnd_a,
  output logic [pipeline_pkg::XLEN-1:0]       o_opnd_b
);

  //////////////////////////////////////////////////////////////////////
  // MA/WB wires
  //////////////////////////////////////////////////////////////////////

  logic [pipeline_pkg::XLEN-1:0]       ma_wb_pc;
  logic [pipeline_pkg::XLEN-1:0]       ma_wb_alu_rslt;
  logic [pipeline_pkg::XLEN-1:0]       ma_wb_mem_data;
  pipeline_pkg::wb_sel_e               ma_wb_sel;
  logic                                ma_wb_reg_write;
  logic [pipeline_pkg::REG_ADDR_W-1:0] ma_wb_rdst;
  logic [pipeline_pkg::XLEN-1:0]       rf_rdata_a;       // Pre-forward reads
  logic [pipeline_pkg::XLEN-1:0]       rf_rdata_b;

  stage_ma #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_ma (
    .clk             (clk),
    .i_rst           (i_rst),
    .i_ma_pc         (i_ma_pc),
    .i_ma_alu_rslt   (i_ma_alu_rslt),
    .i_ma_store_data (i_ma_store_data),
    .i_ma_mem_op     (i_ma_mem_op),
    .i_ma_wb_sel     (i_ma_wb_sel),
    .i_ma_reg_write  (i_ma_reg_write),
    .i_ma_rdst       (i_ma_rdst),
    .o_wb_pc         (ma_wb_pc),
    .o_wb_alu_rslt   (ma_wb_alu_rslt),
    .o_wb_mem_data   (ma_wb_mem_data),
    .o_wb_sel        (ma_wb_sel),
    .o_wb_reg_write  (ma_wb_reg_write),
    .o_wb_rdst       (ma_wb_rdst)
  );

  stage_wb u_wb (
    .clk                (clk),
    .i_rst              (i_rst),
    .i_wb_pc            (ma_wb_pc),
    .i_wb_data_o_ma     (ma_wb_mem_data),
    .i_wb_alu_rslt      (ma_wb_alu_rslt),
    .i_wb_sel           (ma_wb_sel),
    .i_wb_reg_write     (ma_wb_reg_write),
    .i_wb_rdst          (ma_wb_rdst),
    .o_wb_rdst          (o_wb_rdst),
    .o_wb_reg_write_rf  (o_wb_reg_write_rf),
    .o_wb_mux           (o_wb_mux),
    .o_wb_reg_dst_s     (o_wb_reg_dst_s),
    .o_vwb_rdst         (o_vwb_rdst),
    .o_vwb_reg_write_rf (o_vwb_reg_write_rf),
    .o_vwb_mux          (o_vwb_mux)
  );

  //////////////////////////////////////////////////////////////////////
  // Register file and forwarding
  //////////////////////////////////////////////////////////////////////

  reg_file u_rf (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_we      (o_wb_reg_write_rf),  // Write happens at the next edge
    .i_waddr   (o_wb_rdst),
    .i_wdata   (o_wb_mux),
    .i_raddr_a (i_rs_a),
    .i_raddr_b (i_rs_b),
    .o_rdata_a (rf_rdata_a),
    .o_rdata_b (rf_rdata_b)
  );

  operand_fwd u_fwd (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_rs_a     (i_rs_a),
    .i_rs_b     (i_rs_b),
    .i_rf_a     (rf_rdata_a),
    .i_rf_b     (rf_rdata_b),
    .i_wb_rdst  (o_wb_rdst),
    .i_wb_we    (o_wb_reg_write_rf),
    .i_wb_data  (o_wb_mux),
    .i_vwb_rdst (o_vwb_rdst),
    .i_vwb_we   (o_vwb_reg_write_rf),
    .i_vwb_data (o_vwb_mux),
    .o_opnd_a   (o_opnd_a),
    .o_opnd_b   (o_opnd_b)
  );

endmodule

// ==== hw/data_mem.sv ====
//////////////////////////////////////////////////////////////////////
// Data RAM
// Single-port word RAM, write at the clock edge, registered read
// that returns the contents from before the edge
//////////////////////////////////////////////////////////////////////

module data_mem #(
  parameter int DMEM_WORDS = 256  // Depth in words
) (
  input  logic                            clk,
  input  logic                            i_we,     // Write strobe
  input  logic [$clog2(DMEM_WORDS)-1:0]   i_addr,   // Word index
  input  logic [pipeline_pkg::XLEN-1:0]   i_wdata,  // Store data
  output logic [pipeline_pkg::XLEN-1:0]   o_rdata   // Registered read
);

  // Word array that keeps its contents through reset
  logic [pipeline_pkg::XLEN-1:0] mem [DMEM_WORDS];

  //////////////////////////////////////////////////////////////////////
  // Port logic
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wdata;  // Store lands at the edge
    end
    o_rdata <= mem[i_addr];    // Read-before-write
  end

endmodule

// ==== hw/operand_fwd.sv ====
//////////////////////////////////////////////////////////////////////
// Operand forwarding
// Resolves each source operand to its newest value, WB result first,
// then the virtual write-back copy, then register file data
//////////////////////////////////////////////////////////////////////

module operand_fwd (
  input  logic                                clk,
  input  logic                                i_rst,
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_rs_a,      // Source indices
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_rs_b,
  input  logic [pipeline_pkg::XLEN-1:0]       i_rf_a,      // Registered RF reads
  input  logic [pipeline_pkg::XLEN-1:0]       i_rf_b,
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_wb_rdst,   // Current WB
  input  logic                                i_wb_we,
  input  logic [pipeline_pkg::XLEN-1:0]       i_wb_data,
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_vwb_rdst,  // WB one cycle late
  input  logic                                i_vwb_we,
  input  logic [pipeline_pkg::XLEN-1:0]       i_vwb_data,
  output logic [pipeline_pkg::XLEN-1:0]       o_opnd_a,
  output logic [pipeline_pkg::XLEN-1:0]       o_opnd_b
);

  logic [pipeline_pkg::REG_ADDR_W-1:0] rs_a_q;  // Aligned with RF read data
  logic [pipeline_pkg::REG_ADDR_W-1:0] rs_b_q;

  // Newest writer wins; enables never fire for r0
  function automatic logic [pipeline_pkg::XLEN-1:0] pick(
    input logic [pipeline_pkg::REG_ADDR_W-1:0] rs,
    input logic [pipeline_pkg::XLEN-1:0]       rf_data
  );
    logic [pipeline_pkg::XLEN-1:0] val;
    if (i_wb_we && (i_wb_rdst == rs)) begin
      val = i_wb_data;         // Not yet written
    end else if (i_vwb_we && (i_vwb_rdst == rs)) begin
      val = i_vwb_data;        // Written at the read edge
    end else begin
      val = rf_data;
    end
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (i_rst) begin
      rs_a_q <= '0;
      rs_b_q <= '0;
    end else begin
      rs_a_q <= i_rs_a;
      rs_b_q <= i_rs_b;
    end
  end

  // Also follows the WB and VWB inputs read inside pick
  always_comb begin
    o_opnd_a = pick(rs_a_q, i_rf_a);
    o_opnd_b = pick(rs_b_q, i_rf_b);
  end

endmodule

// ==== hw/pipeline_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Pipeline back-end package
// Word and index widths, register count, and the write-back select
// and memory-operation enums shared by the MA and WB stages
//////////////////////////////////////////////////////////////////////

package pipeline_pkg;

  //////////////////////////////////////////////////////////////////////
  // Datapath sizes
  //////////////////////////////////////////////////////////////////////

  localparam int XLEN       = 32;  // Data and address word
  localparam int REG_ADDR_W = 5;   // Register index
  localparam int NUM_REGS   = 32;  // Architectural registers

  //////////////////////////////////////////////////////////////////////
  // Control encodings
  //////////////////////////////////////////////////////////////////////

  // Write-back source select
  typedef enum logic [1:0] {
    WB_SEL_MEM  = 2'b00,  // Load data from RAM
    WB_SEL_ALU  = 2'b01,  // ALU result
    WB_SEL_PC   = 2'b10,  // Link value
    WB_SEL_ZERO = 2'b11   // Constant zero
  } wb_sel_e;

  // Memory operation of the instruction in MA
  typedef enum logic [1:0] {
    MEM_NONE  = 2'b00,  // No access, bubble or ALU op
    MEM_LOAD  = 2'b01,  // Word read
    MEM_STORE = 2'b10   // Word write
  } mem_op_e;

endpackage

// ==== hw/reg_file.sv ====
//////////////////////////////////////////////////////////////////////
// Register file
// 32 x 32-bit registers, one write port, two registered read ports
// returning the contents from before the edge
//////////////////////////////////////////////////////////////////////

module reg_file (
  input  logic                                clk,
  input  logic                                i_rst,
  input  logic                                i_we,       // Already qualified in WB
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_waddr,
  input  logic [pipeline_pkg::XLEN-1:0]       i_wdata,
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_raddr_a,  // Source A index
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_raddr_b,  // Source B index
  output logic [pipeline_pkg::XLEN-1:0]       o_rdata_a,
  output logic [pipeline_pkg::XLEN-1:0]       o_rdata_b
);

  logic [pipeline_pkg::XLEN-1:0] regs [pipeline_pkg::NUM_REGS];

  //////////////////////////////////////////////////////////////////////
  // Write port and register array
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 0; i < pipeline_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;  // r0 included, never written after
      end
    end else if (i_we) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  // Same-edge write is not visible, forwarding covers it
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_rdata_a <= '0;
      o_rdata_b <= '0;
    end else begin
      o_rdata_a <= regs[i_raddr_a];  // Pre-edge contents
      o_rdata_b <= regs[i_raddr_b];
    end
  end

endmodule

// ==== hw/stage_ma.sv ====
//////////////////////////////////////////////////////////////////////
// Memory-access stage
// Drives the data RAM from the execute results and holds the MA/WB
// pipeline register that feeds write-back
//////////////////////////////////////////////////////////////////////

module stage_ma #(
  parameter int DMEM_WORDS = 256  // Data RAM depth
) (
  input  logic                                clk,
  input  logic                                i_rst,
  input  logic [pipeline_pkg::XLEN-1:0]       i_ma_pc,          // Link value
  input  logic [pipeline_pkg::XLEN-1:0]       i_ma_alu_rslt,    // ALU out, also address
  input  logic [pipeline_pkg::XLEN-1:0]       i_ma_store_data,  // Store operand
  input  pipeline_pkg::mem_op_e               i_ma_mem_op,
  input  pipeline_pkg::wb_sel_e               i_ma_wb_sel,
  input  logic                                i_ma_reg_write,   // Unqualified request
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_ma_rdst,
  output logic [pipeline_pkg::XLEN-1:0]       o_wb_pc,
  output logic [pipeline_pkg::XLEN-1:0]       o_wb_alu_rslt,
  output logic [pipeline_pkg::XLEN-1:0]       o_wb_mem_data,    // Load data
  output pipeline_pkg::wb_sel_e               o_wb_sel,
  output logic                                o_wb_reg_write,
  output logic [pipeline_pkg::REG_ADDR_W-1:0] o_wb_rdst
);

  localparam int AW = $clog2(DMEM_WORDS);  // Word index width

  logic                          dmem_we;
  logic [AW-1:0]                 dmem_addr;
  logic [pipeline_pkg::XLEN-1:0] dmem_rdata;
  logic                          load_q;     // Instruction in WB is a load

  //////////////////////////////////////////////////////////////////////
  // RAM access decode
  //////////////////////////////////////////////////////////////////////

  assign dmem_we   = (i_ma_mem_op == pipeline_pkg::MEM_STORE);
  assign dmem_addr = i_ma_alu_rslt[AW+1:2];  // Byte address to word, wraps at depth

  data_mem #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_dmem (
    .clk     (clk),
    .i_we    (dmem_we),
    .i_addr  (dmem_addr),
    .i_wdata (i_ma_store_data),
    .o_rdata (dmem_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // MA/WB pipeline register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_wb_pc        <= '0;
      o_wb_alu_rslt  <= '0;
      o_wb_sel       <= pipeline_pkg::WB_SEL_MEM;
      o_wb_reg_write <= 1'b0;
      o_wb_rdst      <= '0;
      load_q         <= 1'b0;
    end else begin
      o_wb_pc        <= i_ma_pc;
      o_wb_alu_rslt  <= i_ma_alu_rslt;
      o_wb_sel       <= i_ma_wb_sel;
      o_wb_reg_write <= i_ma_reg_write;
      o_wb_rdst      <= i_ma_rdst;
      load_q         <= (i_ma_mem_op == pipeline_pkg::MEM_LOAD);
    end
  end

  // RAM read word only for loads, zero otherwise and after reset
  assign o_wb_mem_data = load_q ? dmem_rdata : '0;

endmodule

// ==== hw/stage_wb.sv ====
//////////////////////////////////////////////////////////////////////
// Write-back stage
// Selects the result among load data, ALU, PC and zero, qualifies the
// write enable and keeps a one-cycle-late copy for forwarding
//////////////////////////////////////////////////////////////////////

module stage_wb (
  input  logic                                clk,
  input  logic                                i_rst,
  input  logic [pipeline_pkg::XLEN-1:0]       i_wb_pc,             // Link value
  input  logic [pipeline_pkg::XLEN-1:0]       i_wb_data_o_ma,      // Load data from MA
  input  logic [pipeline_pkg::XLEN-1:0]       i_wb_alu_rslt,       // ALU result
  input  pipeline_pkg::wb_sel_e               i_wb_sel,            // Result source
  input  logic                                i_wb_reg_write,      // Raw write request
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_wb_rdst,
  output logic [pipeline_pkg::REG_ADDR_W-1:0] o_wb_rdst,
  output logic                                o_wb_reg_write_rf,   // Qualified enable
  output logic [pipeline_pkg::XLEN-1:0]       o_wb_mux,            // Register file data
  output pipeline_pkg::wb_sel_e               o_wb_reg_dst_s,      // Select passed on
  output logic [pipeline_pkg::REG_ADDR_W-1:0] o_vwb_rdst,          // Late copies
  output logic                                o_vwb_reg_write_rf,
  output logic [pipeline_pkg::XLEN-1:0]       o_vwb_mux
);

  //////////////////////////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (i_wb_sel)
      pipeline_pkg::WB_SEL_MEM:  o_wb_mux = i_wb_data_o_ma;
      pipeline_pkg::WB_SEL_ALU:  o_wb_mux = i_wb_alu_rslt;
      pipeline_pkg::WB_SEL_PC:   o_wb_mux = i_wb_pc;
      pipeline_pkg::WB_SEL_ZERO: o_wb_mux = '0;
      default:                   o_wb_mux = '0;
    endcase
  end

  // r0 is hardwired, the only place the enable gets qualified
  assign o_wb_reg_write_rf = i_wb_reg_write && (i_wb_rdst != '0);
  assign o_wb_rdst         = i_wb_rdst;
  assign o_wb_reg_dst_s    = i_wb_sel;

  // One clock late copy for the forwarding unit
  virtual_wb u_vwb (
    .clk                (clk),
    .i_rst              (i_rst),
    .i_vwb_rdst         (o_wb_rdst),
    .i_vwb_reg_write_rf (o_wb_reg_write_rf),
    .i_vwb_mux          (o_wb_mux),
    .o_vwb_rdst         (o_vwb_rdst),
    .o_vwb_reg_write_rf (o_vwb_reg_write_rf),
    .o_vwb_mux          (o_vwb_mux)
  );

endmodule

// ==== hw/virtual_wb.sv ====
//////////////////////////////////////////////////////////////////////
// Virtual write-back
// Holds last cycle's write-back result, destination and enable
//////////////////////////////////////////////////////////////////////

module virtual_wb (
  input  logic                                clk,
  input  logic                                i_rst,
  input  logic [pipeline_pkg::REG_ADDR_W-1:0] i_vwb_rdst,          // WB destination
  input  logic                                i_vwb_reg_write_rf,  // WB qualified enable
  input  logic [pipeline_pkg::XLEN-1:0]       i_vwb_mux,           // WB result
  output logic [pipeline_pkg::REG_ADDR_W-1:0] o_vwb_rdst,
  output logic                                o_vwb_reg_write_rf,
  output logic [pipeline_pkg::XLEN-1:0]       o_vwb_mux
);

  // This value is being written into the register file right now,
  // so a registered read issued at the same edge cannot see it yet
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_vwb_rdst         <= '0;
      o_vwb_reg_write_rf <= 1'b0;  // No stale forward after reset
      o_vwb_mux          <= '0;
    end else begin
      o_vwb_rdst         <= i_vwb_rdst;
      o_vwb_reg_write_rf <= i_vwb_reg_write_rf;
      o_vwb_mux          <= i_vwb_mux;
    end
  end

endmodule

// ==== sim/back_end_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Back-end checker
// Compares WB, VWB and operand ports against queued expectations
//////////////////////////////////////////////////////////////////////

module back_end_checker (
  input logic                  clk,
  input logic                  i_rst,
  input logic [31:0]           o_wb_mux,
  input logic [4:0]            o_wb_rdst,
  input logic                  o_wb_reg_write_rf,
  input pipeline_pkg::wb_sel_e o_wb_reg_dst_s,
  input logic [4:0]            o_vwb_rdst,
  input logic                  o_vwb_reg_write_rf,
  input logic [31:0]           o_vwb_mux,
  input logic [31:0]           o_opnd_a,
  input logic [31:0]           o_opnd_b
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] q_mux[$], q_a[$], q_b[$];
  logic [4:0]  q_rdst[$];
  logic        q_we[$];
  logic [1:0]  q_sel[$];
  int pushed = 0, popped = 0, sampled = 0;
  int check_total = 0, err_total = 0, test_checks = 0, test_errs = 0;
  logic [31:0] prev_mux = '0;  // Last WB expectation, the VWB target
  logic [4:0]  prev_rdst = '0;
  logic        prev_we = 1'b0;

  task automatic push_exp(input logic [31:0] mux, input logic [4:0] rdst, input logic we,
                          input pipeline_pkg::wb_sel_e sel, input logic [31:0] a, b);
    q_mux.push_back(mux);
    q_rdst.push_back(rdst);
    q_we.push_back(we);
    q_sel.push_back(sel);
    q_a.push_back(a);
    q_b.push_back(b);
    pushed++;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_total++;
    test_checks++;
    if (got !== exp) begin
      err_total++;
      test_errs++;
      $display("ERR %s got %08h exp %08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, test_checks, test_errs);
    test_checks = 0;
    test_errs = 0;
  endtask

  // Entries pushed before this edge are now in flight
  always @(posedge clk) sampled = pushed;

  always @(negedge clk) begin
    if (i_rst) begin
      check_val("o_wb_reg_write_rf", 32'(o_wb_reg_write_rf), 32'h0);
      check_val("o_vwb_reg_write_rf", 32'(o_vwb_reg_write_rf), 32'h0);
      check_val("o_opnd_a", o_opnd_a, 32'h0);
      check_val("o_opnd_b", o_opnd_b, 32'h0);
    end else if (popped < sampled) begin
      check_val("o_vwb_mux", o_vwb_mux, prev_mux);
      check_val("o_vwb_rdst", 32'(o_vwb_rdst), 32'(prev_rdst));
      check_val("o_vwb_reg_write_rf", 32'(o_vwb_reg_write_rf), 32'(prev_we));
      prev_mux = q_mux.pop_front();
      prev_rdst = q_rdst.pop_front();
      prev_we = q_we.pop_front();
      check_val("o_wb_mux", o_wb_mux, prev_mux);
      check_val("o_wb_rdst", 32'(o_wb_rdst), 32'(prev_rdst));
      check_val("o_wb_reg_write_rf", 32'(o_wb_reg_write_rf), 32'(prev_we));
      check_val("o_wb_reg_dst_s", 32'(o_wb_reg_dst_s), 32'(q_sel.pop_front()));
      check_val("o_opnd_a", o_opnd_a, q_a.pop_front());
      check_val("o_opnd_b", o_opnd_b, q_b.pop_front());
      popped++;
    end
  end

endmodule

// ==== sim/back_end_sva.sv ====
//////////////////////////////////////////////////////////////////////
// Write-back assertions
// Reset state, r0 enable rule and the one-cycle VWB copy
//////////////////////////////////////////////////////////////////////

module back_end_sva (
  input logic        clk,
  input logic        i_rst,
  input logic [4:0]  o_wb_rdst,
  input logic        o_wb_reg_write_rf,
  input logic [31:0] o_wb_mux,
  input logic [4:0]  o_vwb_rdst,
  input logic        o_vwb_reg_write_rf,
  input logic [31:0] o_vwb_mux
);
  timeunit 1ns;
  timeprecision 100ps;

  a_rst_en : assert property (@(posedge clk) $past(i_rst) |->
                              (!o_wb_reg_write_rf && !o_vwb_reg_write_rf))
    else $error("enable high during reset");

  // Registered copy must keep enable and destination paired
  a_no_r0 : assert property (@(posedge clk) o_vwb_reg_write_rf |-> (o_vwb_rdst != 5'd0))
    else $error("VWB write enable with destination r0");

  // VWB trails WB by exactly one clock
  a_vwb : assert property (@(posedge clk) (!i_rst && !$past(i_rst)) |->
                           (o_vwb_mux == $past(o_wb_mux) && o_vwb_rdst == $past(o_wb_rdst)
                            && o_vwb_reg_write_rf == $past(o_wb_reg_write_rf)))
    else $error("VWB outputs differ from previous WB outputs");

endmodule

bind stage_wb back_end_sva u_sva (
  .clk                (clk),
  .i_rst              (i_rst),
  .o_wb_rdst          (o_wb_rdst),
  .o_wb_reg_write_rf  (o_wb_reg_write_rf),
  .o_wb_mux           (o_wb_mux),
  .o_vwb_rdst         (o_vwb_rdst),
  .o_vwb_reg_write_rf (o_vwb_reg_write_rf),
  .o_vwb_mux          (o_vwb_mux)
);

// ==== sim/tb_back_end.sv ====
//////////////////////////////////////////////////////////////////////
// Back-end testbench
// Drives execute results and source indices into the DUT, keeps a
// reference model of RAM and registers, and feeds the checker
//////////////////////////////////////////////////////////////////////

module tb_back_end;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DMEM_WORDS   = 256;
  localparam int AW           = $clog2(DMEM_WORDS);
  localparam int TOTAL_CYCLES = 16 + 40 + DMEM_WORDS + 20 + 10 + 10 + 20 + 410;

  logic                        clk = 1'b0;
  logic                        i_rst;
  logic [31:0]                 i_ma_pc, i_ma_alu_rslt, i_ma_store_data;
  pipeline_pkg::mem_op_e       i_ma_mem_op;
  pipeline_pkg::wb_sel_e       i_ma_wb_sel;
  logic                        i_ma_reg_write;
  logic [4:0]                  i_ma_rdst, i_rs_a, i_rs_b;
  logic [31:0]                 o_wb_mux, o_vwb_mux, o_opnd_a, o_opnd_b;
  logic [4:0]                  o_wb_rdst, o_vwb_rdst;
  logic                        o_wb_reg_write_rf, o_vwb_reg_write_rf;
  pipeline_pkg::wb_sel_e       o_wb_reg_dst_s;

  logic [31:0] model_mem  [DMEM_WORDS];  // Expected RAM contents
  logic [31:0] model_regs [32];          // Expected registers
  logic [31:0] rnd_state = 32'h0d8d_eb93;
  int          n_tests = 0;

  always #5 clk = ~clk;  // 10 ns period

  back_end_top #(.DMEM_WORDS(DMEM_WORDS)) uut (.*);

  back_end_checker u_chk (.*);

  //////////////////////////////////////////////////////////////////////
  // Reference model and stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Applies one instruction, then reads the newest source values
  function void model_step(
    input  logic [31:0] pc, alu, sd,
    input  pipeline_pkg::mem_op_e op,
    input  pipeline_pkg::wb_sel_e sel,
    input  logic rw,
    input  logic [4:0] rdst, rs_a, rs_b,
    output logic [31:0] e_mux,
    output logic e_we,
    output logic [31:0] e_a, e_b
  );
    logic [AW-1:0] addr;
    logic [31:0]   ld;
    addr = AW'((alu >> 2) % DMEM_WORDS);  // Word index wraps at depth
    ld   = (op == pipeline_pkg::MEM_LOAD) ? model_mem[addr] : 32'h0;  // Old contents
    case (sel)
      pipeline_pkg::WB_SEL_MEM: e_mux = ld;
      pipeline_pkg::WB_SEL_ALU: e_mux = alu;
      pipeline_pkg::WB_SEL_PC:  e_mux = pc;
      default:                  e_mux = 32'h0;
    endcase
    e_we = rw && (rdst != 5'd0);  // r0 never written
    if (op == pipeline_pkg::MEM_STORE) model_mem[addr] = sd;
    if (e_we) model_regs[rdst] = e_mux;
    e_a = model_regs[rs_a];
    e_b = model_regs[rs_b];
  endfunction

  task automatic drive_instr(
    input logic [31:0] pc, alu, sd,
    input pipeline_pkg::mem_op_e op,
    input pipeline_pkg::wb_sel_e sel,
    input logic rw,
    input logic [4:0] rdst, rs_a, rs_b
  );
    logic [31:0] e_mux;
    logic [31:0] e_a;
    logic [31:0] e_b;
    logic        e_we;
    i_ma_pc = pc;
    i_ma_alu_rslt = alu;
    i_ma_store_data = sd;
    i_ma_mem_op = op;
    i_ma_wb_sel = sel;
    i_ma_reg_write = rw;
    i_ma_rdst = rdst;
    i_rs_a = rs_a;
    i_rs_b = rs_b;
    model_step(pc, alu, sd, op, sel, rw, rdst, rs_a, rs_b, e_mux, e_we, e_a, e_b);
    u_chk.push_exp(e_mux, rdst, e_we, sel, e_a, e_b);
    @(posedge clk);
    #1;  // Inputs change just after the edge
  endtask

  task automatic bubble();
    drive_instr(0, 0, 0, pipeline_pkg::MEM_NONE, pipeline_pkg::WB_SEL_ZERO, 1'b0, 0, 0, 0);
  endtask

  task automatic end_test(input string name);
    bubble();
    bubble();
    while (u_chk.popped != u_chk.pushed) @(negedge clk);  // Drain expectations
    u_chk.report_test(name);
    n_tests++;
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r_op;
    logic [31:0] r_val;
    logic [31:0] r_idx;
    pipeline_pkg::mem_op_e op;
    pipeline_pkg::wb_sel_e sel;
    i_rst = 1'b1;
    i_ma_pc = '0;
    i_ma_alu_rslt = '0;
    i_ma_store_data = '0;
    i_ma_mem_op = pipeline_pkg::MEM_NONE;
    i_ma_wb_sel = pipeline_pkg::WB_SEL_ZERO;
    i_ma_reg_write = 1'b0;
    i_ma_rdst = '0;
    i_rs_a = '0;
    i_rs_b = '0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (16) @(posedge clk);
    #1;
    i_rst = 1'b0;

    // Every register reads zero after reset
    for (int i = 0; i < 32; i++) begin
      drive_instr(0, 0, 0, pipeline_pkg::MEM_NONE, pipeline_pkg::WB_SEL_ZERO, 1'b0, 0,
                  5'(i), 5'(31 - i));
    end
    end_test("reset");

    // Fill the whole RAM, then load back, then store and load at once
    for (int a = 0; a < DMEM_WORDS; a++) begin
      drive_instr(32'h100, 32'(a * 4), (32'(a) * 32'h9e37_79b9) ^ 32'h5a5a_0000 ^ 32'(a),
                  pipeline_pkg::MEM_STORE, pipeline_pkg::WB_SEL_ALU, 1'b0, 0, 0, 0);
    end
    for (int a = 0; a < 16; a++) begin
      drive_instr(0, 32'(a * 68), 0, pipeline_pkg::MEM_LOAD, pipeline_pkg::WB_SEL_MEM,
                  1'b1, 5'(a + 1), 5'(a + 1), 0);
    end
    drive_instr(0, 32'h40, 32'hcafe_f00d, pipeline_pkg::MEM_STORE, pipeline_pkg::WB_SEL_ALU,
                1'b0, 0, 0, 0);
    drive_instr(0, 32'h40, 0, pipeline_pkg::MEM_LOAD, pipeline_pkg::WB_SEL_MEM, 1'b1, 9, 9, 0);
    end_test("store_load");

    drive_instr(32'h0000_1234, 32'h89ab_cdef, 0, pipeline_pkg::MEM_NONE,
                pipeline_pkg::WB_SEL_ALU, 1'b1, 3, 3, 0);
    drive_instr(32'h0000_1238, 32'h1111_2222, 0, pipeline_pkg::MEM_NONE,
                pipeline_pkg::WB_SEL_PC, 1'b1, 4, 4, 3);
    drive_instr(32'h0000_123c, 32'h3333_4444, 0, pipeline_pkg::MEM_NONE,
                pipeline_pkg::WB_SEL_ZERO, 1'b1, 5, 5, 4);
    end_test("source_select");

    drive_instr(0, 32'hdead_beef, 0, pipeline_pkg::MEM_NONE, pipeline_pkg::WB_SEL_ALU,
                1'b1, 0, 0, 0);
    repeat (3) drive_instr(0, 0, 0, pipeline_pkg::MEM_NONE, pipeline_pkg::WB_SEL_ZERO,
                           1'b0, 0, 0, 0);
    end_test("reg_zero");

    // Read r7 while it sits in WB, then VWB, then the register file
    drive_instr(0, 32'h7777_0001, 0, pipeline_pkg::MEM_NONE, pipeline_pkg::WB_SEL_ALU,
                1'b1, 7, 7, 7);
    drive_instr(0, 32'h7777_0002, 0, pipeline_pkg::MEM_NONE, pipeline_pkg::WB_SEL_ALU,
                1'b1, 7, 7, 7);
    repeat (3) drive_instr(0, 0, 0, pipeline_pkg::MEM_NONE, pipeline_pkg::WB_SEL_ZERO,
                           1'b0, 0, 7, 7);
    end_test("forwarding");

    for (int n = 0; n < 400; n++) begin
      rnd_state = xorshift(rnd_state);
      r_op = rnd_state;
      rnd_state = xorshift(rnd_state);
      r_val = rnd_state;
      rnd_state = xorshift(rnd_state);
      r_idx = rnd_state;
      case (r_op[1:0])
        2'd1:    op = pipeline_pkg::MEM_LOAD;
        2'd2:    op = pipeline_pkg::MEM_STORE;
        default: op = pipeline_pkg::MEM_NONE;
      endcase
      // Load data is only selected by loads
      if (op == pipeline_pkg::MEM_LOAD) sel = pipeline_pkg::WB_SEL_MEM;
      else if (r_op[3:2] == 2'd0) sel = pipeline_pkg::WB_SEL_ZERO;
      else sel = pipeline_pkg::wb_sel_e'(r_op[3:2]);
      drive_instr(r_idx ^ r_val, r_val, r_idx, op, sel, r_op[4], r_idx[4:0],
                  r_idx[9:5], r_idx[14:10]);
    end
    end_test("random_mix");

    $display("summary: %0d tests, %0d checks, %0d errors",
             n_tests, u_chk.check_total, u_chk.err_total);
    if (u_chk.err_total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the test lengths
  initial begin
    #(TOTAL_CYCLES * 10 + 1000);
    $display("timeout: the run did not finish within the expected time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule
